// File: Bender.yml
package:
  name: hpm

export_include_dirs:
  - include

sources:
  - files:
      - hdl/hpm_pkg.sv
      - hdl/hpm_commit_classifier.sv
      - hdl/hpm_counters.sv
      - hdl/hpm_fixed_csrs.sv
      - hdl/hpm_top.sv
  - target: test
    files:
      - dv/tb_hpm_top.sv

// File: dv/tb_hpm_top.sv
// Directed testbench for the HPM top level with CSR tasks, check task, tests, timeout and summary
`include "hpm_settings.svh"

module tb_hpm_top
  import hpm_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned max_cycles = 4000;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 debug_mode;
  csr_addr_t                            addr_i;
  logic                                 we_i;
  xlen_t                                wdata_i;
  xlen_t                                rdata_o;
  logic                                 access_fault_o;
  logic [`HPM_COMMIT_PORTS-1:0]         commit_ack;
  fu_t      [`HPM_COMMIT_PORTS-1:0]     commit_fu;
  op_t      [`HPM_COMMIT_PORTS-1:0]     commit_op;
  reg_idx_t [`HPM_COMMIT_PORTS-1:0]     commit_rd;
  logic [9:0]                           ext_ev;    // One bit per external event level

  integer      seed = 32'hedf9_5bdd;
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned cycle_cnt;
  logic        last_fault;                         // Fault seen in the last write cycle

  hpm_top DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .debug_mode_i   (debug_mode),
    .addr_i         (addr_i),
    .we_i           (we_i),
    .wdata_i        (wdata_i),
    .rdata_o        (rdata_o),
    .access_fault_o (access_fault_o),
    .commit_ack_i   (commit_ack),
    .commit_fu_i    (commit_fu),
    .commit_op_i    (commit_op),
    .commit_rd_i    (commit_rd),
    .icache_miss_i  (ext_ev[0]),
    .dcache_miss_i  (ext_ev[1]),
    .itlb_miss_i    (ext_ev[2]),
    .dtlb_miss_i    (ext_ev[3]),
    .exception_i    (ext_ev[4]),
    .eret_i         (ext_ev[5]),
    .mispredict_i   (ext_ev[6]),
    .sb_full_i      (ext_ev[7]),
    .if_empty_i     (ext_ev[8]),
    .issue_stall_i  (ext_ev[9])
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("TIMEOUT: the run did not finish within %0d cycles", max_cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Selector code of each bit of ext_ev
  function automatic event_sel_t ext_code(input int idx);
    case (idx)
      0:       return `EV_ICACHE_MISS;
      1:       return `EV_DCACHE_MISS;
      2:       return `EV_ITLB_MISS;
      3:       return `EV_DTLB_MISS;
      4:       return `EV_EXCEPTION;
      5:       return `EV_ERET;
      6:       return `EV_MISPREDICT;
      7:       return `EV_SB_FULL;
      8:       return `EV_IF_EMPTY;
      default: return `EV_ISSUE_STALL;
    endcase
  endfunction

  // Load, call, return, integer, float
  function automatic event_sel_t class_code(input int kind);
    case (kind)
      0:       return `EV_LOAD;
      1:       return `EV_CALL;
      2:       return `EV_RETURN;
      3:       return `EV_INT_INSTR;
      default: return `EV_FP_INSTR;
    endcase
  endfunction

  task automatic check(input string sig, input logic [63:0] act, input logic [63:0] exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: actual 0x%h expected 0x%h", sig, act, exp);
    end
  endtask

  // Each access takes one cycle and starts on a falling edge
  task automatic csr_write(input csr_addr_t a, input xlen_t d);
    addr_i  = a;
    wdata_i = d;
    we_i    = 1'b1;
    #1 last_fault = access_fault_o;
    @(negedge clk_i);
    we_i = 1'b0;
  endtask

  task automatic csr_read(input csr_addr_t a, output xlen_t d);
    addr_i = a;
    we_i   = 1'b0;
    #1 d = rdata_o;     // Stable until the next rising edge
    @(negedge clk_i);
  endtask

  task automatic read_expect(input csr_addr_t a, input xlen_t exp);
    xlen_t v;
    csr_read(a, v);
    check($sformatf("rdata_o[0x%h]", a), v, exp);
  endtask

  task automatic clear_counter(input int k);
    csr_write(csr_addr_t'(`CSR_MHPMCOUNTER3 + k), '0);
    csr_write(csr_addr_t'(`CSR_MHPMCOUNTER3H + k), '0);
  endtask

  task automatic report_test(input string name, input int unsigned start_errs);
    $display("%s: %0d errors", name, n_errors - start_errs);
  endtask

  task automatic reset_readback();
    int unsigned start;
    start = n_errors;
    check("access_fault_o", access_fault_o, 1'b0);
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
      read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3 + i), '0);
      read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3H + i), '0);
      read_expect(csr_addr_t'(`CSR_MHPMEVENT3 + i), '0);
    end
    read_expect(`CSR_MCOUNTINHIBIT, '0);
    read_expect(`CSR_MINSTRET, '0);
    read_expect(`CSR_MINSTRETH, '0);
    // Written values hold while all events stay low
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
      csr_write(csr_addr_t'(`CSR_MHPMCOUNTER3 + i), 32'h1234_0000 + i * 32'h111);
      csr_write(csr_addr_t'(`CSR_MHPMCOUNTER3H + i), 32'hABCD_0000 + i);
      csr_write(csr_addr_t'(`CSR_MHPMEVENT3 + i), 32'hFFFF_FFE0 | (12 + i));
    end
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
      read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3 + i), 32'h1234_0000 + i * 32'h111);
      read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3H + i), 32'hABCD_0000 + i);
      read_expect(csr_addr_t'(`CSR_MHPMEVENT3 + i), 12 + i);  // Low five bits only
      csr_write(csr_addr_t'(`CSR_MHPMEVENT3 + i), '0);
    end
    report_test("reset and readback", start);
  endtask

  task automatic ext_event_counts();
    int unsigned start;
    int unsigned n;
    int          k;
    start = n_errors;
    clear_counter(5);                              // Stays on selector 0
    for (int idx = 0; idx < 10; idx++) begin
      k = idx % 5;
      n = 0;
      clear_counter(k);
      csr_write(csr_addr_t'(`CSR_MHPMEVENT3 + k), xlen_t'(ext_code(idx)));
      repeat (64) begin
        ext_ev     = $random(seed);
        commit_ack = $random(seed);
        commit_fu  = $random(seed);
        commit_op  = $random(seed);
        commit_rd  = $random(seed);
        if (ext_ev[idx]) n++;
        @(negedge clk_i);
      end
      ext_ev     = '0;
      commit_ack = '0;
      read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3 + k), n);
      read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3H + k), '0);
      csr_write(csr_addr_t'(`CSR_MHPMEVENT3 + k), '0);
    end
    read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3 + 5), '0);
    read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3H + 5), '0);
    report_test("external events", start);
  endtask

  task automatic commit_event_counts();
    int unsigned start;
    int unsigned n_ev [5];
    int unsigned n_ret;
    logic [4:0]  hit;
    int          kind;
    start = n_errors;
    n_ret = 0;
    for (int k = 0; k < 5; k++) begin
      n_ev[k] = 0;
      clear_counter(k);
      csr_write(csr_addr_t'(`CSR_MHPMEVENT3 + k), xlen_t'(class_code(k)));
    end
    csr_write(`CSR_MINSTRET, '0);
    csr_write(`CSR_MINSTRETH, '0);
    repeat (120) begin
      hit = '0;
      for (int p = 0; p < `HPM_COMMIT_PORTS; p++) begin
        commit_ack[p] = $random(seed);
        kind = {$random(seed)} % 5;
        case (kind)
          0: begin
            commit_fu[p] = `FU_LOAD;
            commit_op[p] = `OP_OTHER;
            commit_rd[p] = 10;
          end
          1: begin
            commit_fu[p] = `FU_CTRL_FLOW;
            commit_op[p] = `OP_JAL;
            commit_rd[p] = 1;
          end
          2: begin
            commit_fu[p] = `FU_CTRL_FLOW;
            commit_op[p] = `OP_JALR;
            commit_rd[p] = 0;
          end
          3: begin
            commit_fu[p] = p ? `FU_MULT : `FU_ALU;
            commit_op[p] = `OP_OTHER;
            commit_rd[p] = 7;
          end
          default: begin
            commit_fu[p] = `FU_FPU;
            commit_op[p] = `OP_OTHER;
            commit_rd[p] = 3;
          end
        endcase
        if (commit_ack[p]) begin
          hit[kind] = 1'b1;
          n_ret++;
        end
      end
      for (int k = 0; k < 5; k++) begin
        if (hit[k]) n_ev[k]++;                     // Counted once per cycle and not per port
      end
      @(negedge clk_i);
    end
    commit_ack = '0;
    for (int k = 0; k < 5; k++) begin
      read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3 + k), n_ev[k]);
      csr_write(csr_addr_t'(`CSR_MHPMEVENT3 + k), '0);
    end
    read_expect(`CSR_MINSTRET, n_ret);
    read_expect(`CSR_MINSTRETH, '0);
    report_test("commit events", start);
  endtask

  task automatic counting_stops();
    int unsigned start;
    start = n_errors;
    clear_counter(0);
    clear_counter(1);
    csr_write(`CSR_MHPMEVENT3, xlen_t'(`EV_ICACHE_MISS));
    csr_write(csr_addr_t'(`CSR_MHPMEVENT3 + 1), xlen_t'(`EV_ICACHE_MISS));
    ext_ev[0] = 1'b1;                              // Miss held high throughout
    repeat (10) @(negedge clk_i);
    csr_write(`CSR_MCOUNTINHIBIT, 32'h8);          // Counter 0 off
    repeat (10) @(negedge clk_i);
    csr_write(`CSR_MCOUNTINHIBIT, '0);
    debug_mode = 1'b1;
    repeat (10) @(negedge clk_i);
    debug_mode = 1'b0;
    repeat (5) csr_write(12'h7C0, '0);             // Write cycles to an unmapped CSR
    ext_ev[0] = 1'b0;
    read_expect(`CSR_MHPMCOUNTER3, 10);
    read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3 + 1), 20);
    report_test("inhibit, debug and write stalls", start);
  endtask

  task automatic mcycle_delta_freeze();
    int unsigned start;
    xlen_t       a;
    xlen_t       b;
    start = n_errors;
    csr_read(`CSR_MCYCLE, a);
    repeat (9) @(negedge clk_i);
    csr_read(`CSR_MCYCLE, b);
    check("mcycle delta", b - a, 10);
    csr_read(`CSR_MCYCLE, a);
    debug_mode = 1'b1;                             // One counting edge before debug
    repeat (8) @(negedge clk_i);
    debug_mode = 1'b0;
    csr_read(`CSR_MCYCLE, b);
    check("mcycle delta in debug", b - a, 1);
    csr_write(`CSR_MCOUNTINHIBIT, 32'hFFFF_FFFF);
    read_expect(`CSR_MCOUNTINHIBIT, 32'h1FD);      // Bit 1 and bits above 8 read zero
    csr_write(`CSR_MCOUNTINHIBIT, 32'h1);
    read_expect(`CSR_MCOUNTINHIBIT, 32'h1);
    csr_write(`CSR_MCYCLE, 32'h0000_1000);
    repeat (9) @(negedge clk_i);
    read_expect(`CSR_MCYCLE, 32'h0000_1000);
    csr_write(`CSR_MCOUNTINHIBIT, '0);
    report_test("mcycle", start);
  endtask

  task automatic alias_access();
    int unsigned start;
    start = n_errors;
    csr_write(`CSR_MCOUNTINHIBIT, 32'h1FD);        // Freeze everything
    csr_write(`CSR_MCYCLE, 32'h1357_9BDF);
    csr_write(`CSR_MCYCLEH, 32'h2);
    csr_write(`CSR_MINSTRET, 32'h2468_ACE0);
    csr_write(`CSR_MINSTRETH, 32'h3);
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
      csr_write(csr_addr_t'(`CSR_MHPMCOUNTER3 + i), 32'hC0DE_0000 | i);
      csr_write(csr_addr_t'(`CSR_MHPMCOUNTER3H + i), 32'h0BAD_0000 | i);
    end
    read_expect(`CSR_CYCLE, 32'h1357_9BDF);
    check("access_fault_o", access_fault_o, 1'b0); // Alias reads do not fault
    read_expect(`CSR_CYCLEH, 32'h2);
    read_expect(`CSR_INSTRET, 32'h2468_ACE0);
    read_expect(`CSR_INSTRETH, 32'h3);
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
      read_expect(csr_addr_t'(`CSR_HPMCOUNTER3 + i), 32'hC0DE_0000 | i);
      read_expect(csr_addr_t'(`CSR_HPMCOUNTER3H + i), 32'h0BAD_0000 | i);
    end
    csr_write(`CSR_CYCLE, 32'hFFFF_FFFF);
    check("access_fault_o", last_fault, 1'b1);
    csr_write(`CSR_INSTRETH, '0);
    check("access_fault_o", last_fault, 1'b1);
    csr_write(csr_addr_t'(`CSR_HPMCOUNTER3 + 2), '0);
    check("access_fault_o", last_fault, 1'b1);
    csr_write(csr_addr_t'(`CSR_HPMCOUNTER3H + 5), '0);
    check("access_fault_o", last_fault, 1'b1);
    read_expect(`CSR_MCYCLE, 32'h1357_9BDF);
    read_expect(`CSR_MINSTRETH, 32'h3);
    read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3 + 2), 32'hC0DE_0002);
    read_expect(csr_addr_t'(`CSR_MHPMCOUNTER3H + 5), 32'h0BAD_0005);
    // Unmapped addresses
    csr_write(12'h7C0, 32'hFFFF_FFFF);
    check("access_fault_o", last_fault, 1'b0);
    read_expect(12'h7C0, '0);
    read_expect(12'hB1F, '0);
    read_expect(12'h329, '0);
    report_test("user aliases and unmapped", start);
  endtask

  initial begin
    rst_ni     = 1'b0;
    debug_mode = 1'b0;
    addr_i     = '0;
    we_i       = 1'b0;
    wdata_i    = '0;
    commit_ack = '0;
    commit_fu  = '0;
    commit_op  = '0;
    commit_rd  = '0;
    ext_ev     = '0;
    n_checks   = 0;
    n_errors   = 0;
    cycle_cnt  = 0;
    last_fault = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    reset_readback();
    ext_event_counts();
    commit_event_counts();
    counting_stops();
    mcycle_delta_freeze();
    alias_access();
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
hdl/hpm_pkg.sv
hdl/hpm_commit_classifier.sv
hdl/hpm_counters.sv
hdl/hpm_fixed_csrs.sv
hdl/hpm_top.sv
dv/tb_hpm_top.sv

// File: hdl/hpm_commit_classifier.sv
// Commit-port classifier producing per-cycle instruction event flags and retire count
`include "hpm_settings.svh"

module hpm_commit_classifier
  import hpm_pkg::*;
(
  input  logic [`HPM_COMMIT_PORTS-1:0]     commit_ack_i,
  input  fu_t      [`HPM_COMMIT_PORTS-1:0] commit_fu_i,
  input  op_t      [`HPM_COMMIT_PORTS-1:0] commit_op_i,
  input  reg_idx_t [`HPM_COMMIT_PORTS-1:0] commit_rd_i,
  output logic                             load_o,
  output logic                             store_o,
  output logic                             branch_o,
  output logic                             call_o,
  output logic                             return_o,
  output logic                             int_o,
  output logic                             fp_o,
  output retire_cnt_t                      retire_cnt_o
);

  logic is_jump;
  logic link_rd;

  always_comb begin
    load_o       = 1'b0;
    store_o      = 1'b0;
    branch_o     = 1'b0;
    call_o       = 1'b0;
    return_o     = 1'b0;
    int_o        = 1'b0;
    fp_o         = 1'b0;
    retire_cnt_o = '0;
    is_jump      = 1'b0;
    link_rd      = 1'b0;

    for (int p = 0; p < `HPM_COMMIT_PORTS; p++) begin
      // x1 and x5 are the link registers of the calling convention
      is_jump = (commit_op_i[p] == `OP_JAL) || (commit_op_i[p] == `OP_JALR);
      link_rd = (commit_rd_i[p] == reg_idx_t'(1)) || (commit_rd_i[p] == reg_idx_t'(5));

      if (commit_ack_i[p]) begin
        load_o   |= (commit_fu_i[p] == `FU_LOAD);
        store_o  |= (commit_fu_i[p] == `FU_STORE);
        branch_o |= (commit_fu_i[p] == `FU_CTRL_FLOW);
        call_o   |= (commit_fu_i[p] == `FU_CTRL_FLOW) && is_jump && link_rd;
        // Plain jalr to x0
        return_o |= (commit_op_i[p] == `OP_JALR) && (commit_rd_i[p] == reg_idx_t'(0));
        int_o    |= (commit_fu_i[p] == `FU_ALU) || (commit_fu_i[p] == `FU_MULT);
        fp_o     |= (commit_fu_i[p] == `FU_FPU);
      end

      retire_cnt_o = retire_cnt_o + retire_cnt_t'(commit_ack_i[p]);
    end
  end

endmodule

// File: hdl/hpm_counters.sv
// Programmable counter bank with event selectors, inhibit and CSR access
`include "hpm_settings.svh"

module hpm_counters
  import hpm_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         debug_mode_i,
  // CSR port
  input  csr_addr_t                    addr_i,
  input  logic                         we_i,
  input  xlen_t                        wdata_i,
  output xlen_t                        rdata_o,      // Zero outside this bank
  // External event levels
  input  logic                         icache_miss_i,
  input  logic                         dcache_miss_i,
  input  logic                         itlb_miss_i,
  input  logic                         dtlb_miss_i,
  input  logic                         exception_i,
  input  logic                         eret_i,
  input  logic                         mispredict_i,
  input  logic                         sb_full_i,
  input  logic                         if_empty_i,
  input  logic                         issue_stall_i,
  // Classifier flags
  input  logic                         load_i,
  input  logic                         store_i,
  input  logic                         branch_i,
  input  logic                         call_i,
  input  logic                         return_i,
  input  logic                         int_i,
  input  logic                         fp_i,
  // mcountinhibit bits 3 and up
  input  logic [`HPM_NUM_COUNTERS-1:0] inhibit_i
);

  counter_t   cnt_q [`HPM_NUM_COUNTERS];
  counter_t   cnt_d [`HPM_NUM_COUNTERS];
  event_sel_t sel_q [`HPM_NUM_COUNTERS];
  event_sel_t sel_d [`HPM_NUM_COUNTERS];

  logic [`HPM_NUM_EVENTS-1:0]   ev_vec;
  logic [`HPM_NUM_COUNTERS-1:0] ev_sel;
  logic                         count_en;

  // Address hits per counter
  logic [`HPM_NUM_COUNTERS-1:0] hit_lo;
  logic [`HPM_NUM_COUNTERS-1:0] hit_hi;
  logic [`HPM_NUM_COUNTERS-1:0] hit_alias_lo;
  logic [`HPM_NUM_COUNTERS-1:0] hit_alias_hi;
  logic [`HPM_NUM_COUNTERS-1:0] hit_sel;

  // Event levels indexed by selector code
  always_comb begin
    ev_vec                  = '0;
    ev_vec[`EV_NONE]        = 1'b0;
    ev_vec[`EV_ICACHE_MISS] = icache_miss_i;
    ev_vec[`EV_DCACHE_MISS] = dcache_miss_i;
    ev_vec[`EV_ITLB_MISS]   = itlb_miss_i;
    ev_vec[`EV_DTLB_MISS]   = dtlb_miss_i;
    ev_vec[`EV_LOAD]        = load_i;
    ev_vec[`EV_STORE]       = store_i;
    ev_vec[`EV_EXCEPTION]   = exception_i;
    ev_vec[`EV_ERET]        = eret_i;
    ev_vec[`EV_BRANCH]      = branch_i;
    ev_vec[`EV_MISPREDICT]  = mispredict_i;
    ev_vec[`EV_CALL]        = call_i;
    ev_vec[`EV_RETURN]      = return_i;
    ev_vec[`EV_SB_FULL]     = sb_full_i;
    ev_vec[`EV_IF_EMPTY]    = if_empty_i;
    ev_vec[`EV_INT_INSTR]   = int_i;
    ev_vec[`EV_FP_INSTR]    = fp_i;
    ev_vec[`EV_ISSUE_STALL] = issue_stall_i;
  end

  always_comb begin
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
      // Codes past the table select nothing
      if (sel_q[i] < event_sel_t'(`HPM_NUM_EVENTS)) begin
        ev_sel[i] = ev_vec[sel_q[i]];
      end else begin
        ev_sel[i] = 1'b0;
      end
      hit_lo[i]       = (addr_i == csr_addr_t'(`CSR_MHPMCOUNTER3 + i));
      hit_hi[i]       = (addr_i == csr_addr_t'(`CSR_MHPMCOUNTER3H + i));
      hit_alias_lo[i] = (addr_i == csr_addr_t'(`CSR_HPMCOUNTER3 + i));
      hit_alias_hi[i] = (addr_i == csr_addr_t'(`CSR_HPMCOUNTER3H + i));
      hit_sel[i]      = (addr_i == csr_addr_t'(`CSR_MHPMEVENT3 + i));
    end
  end

  assign count_en = !debug_mode_i && !we_i; // CSR write cycles never count

  // Aliases read the same halves as the machine counters
  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
      if (hit_lo[i] || hit_alias_lo[i]) begin
        rdata_o = cnt_q[i][31:0];
      end else if (hit_hi[i] || hit_alias_hi[i]) begin
        rdata_o = cnt_q[i][63:32];
      end else if (hit_sel[i]) begin
        rdata_o = xlen_t'(sel_q[i]);
      end
    end
  end

  // A write takes precedence over counting
  always_comb begin
    cnt_d = cnt_q;
    sel_d = sel_q;
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
      if (count_en && ev_sel[i] && !inhibit_i[i]) begin
        cnt_d[i] = cnt_q[i] + counter_t'(1);
      end
      if (we_i) begin
        if (hit_lo[i]) begin
          cnt_d[i][31:0] = wdata_i;
        end
        if (hit_hi[i]) begin
          cnt_d[i][63:32] = wdata_i;
        end
        if (hit_sel[i]) begin
          sel_d[i] = wdata_i[4:0]; // Upper bits dropped
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '{default: '0};
      sel_q <= '{default: '0};
    end else begin
      cnt_q <= cnt_d;
      sel_q <= sel_d;
    end
  end

endmodule

// File: hdl/hpm_fixed_csrs.sv
// mcycle, minstret and mcountinhibit registers, alias decode, read mux and write fault
`include "hpm_settings.svh"

module hpm_fixed_csrs
  import hpm_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         debug_mode_i,
  input  csr_addr_t                    addr_i,
  input  logic                         we_i,
  input  xlen_t                        wdata_i,
  input  retire_cnt_t                  retire_cnt_i,
  input  xlen_t                        bank_rdata_i,   // From the counter bank
  output logic [`HPM_NUM_COUNTERS-1:0] inhibit_o,
  output xlen_t                        rdata_o,
  output logic                         access_fault_o
);

  localparam int unsigned inh_width = `HPM_NUM_COUNTERS + 3;

  // Bit 1 has no counter behind it
  localparam logic [inh_width-1:0] inh_wr_mask = {{(`HPM_NUM_COUNTERS + 1){1'b1}}, 1'b0, 1'b1};

  counter_t             mcycle_q;
  counter_t             mcycle_d;
  counter_t             minstret_q;
  counter_t             minstret_d;
  logic [inh_width-1:0] minh_q;
  logic [inh_width-1:0] minh_d;
  logic                 count_en;

  assign count_en  = !debug_mode_i && !we_i;
  assign inhibit_o = minh_q[inh_width-1:3];

  // User aliases at 0xC00..0xC1F and 0xC80..0xC9F are read-only
  assign access_fault_o = we_i && ((addr_i[11:5] == 7'h60) || (addr_i[11:5] == 7'h64));

  always_comb begin
    mcycle_d   = mcycle_q;
    minstret_d = minstret_q;
    minh_d     = minh_q;

    if (count_en && !minh_q[0]) begin
      mcycle_d = mcycle_q + counter_t'(1);
    end
    if (count_en && !minh_q[2]) begin
      minstret_d = minstret_q + counter_t'(retire_cnt_i);
    end

    if (we_i) begin
      case (addr_i)
        `CSR_MCYCLE:        mcycle_d[31:0]    = wdata_i;
        `CSR_MCYCLEH:       mcycle_d[63:32]   = wdata_i;
        `CSR_MINSTRET:      minstret_d[31:0]  = wdata_i;
        `CSR_MINSTRETH:     minstret_d[63:32] = wdata_i;
        `CSR_MCOUNTINHIBIT: minh_d = wdata_i[inh_width-1:0] & inh_wr_mask;
        default: ;
      endcase
    end
  end

  // Own registers and aliases first, then the bank
  always_comb begin
    case (addr_i)
      `CSR_MCYCLE,   `CSR_CYCLE:    rdata_o = mcycle_q[31:0];
      `CSR_MCYCLEH,  `CSR_CYCLEH:   rdata_o = mcycle_q[63:32];
      `CSR_MINSTRET, `CSR_INSTRET:  rdata_o = minstret_q[31:0];
      `CSR_MINSTRETH, `CSR_INSTRETH: rdata_o = minstret_q[63:32];
      `CSR_MCOUNTINHIBIT:           rdata_o = xlen_t'(minh_q);
      default:                      rdata_o = bank_rdata_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
      minh_q     <= '0;
    end else begin
      mcycle_q   <= mcycle_d;
      minstret_q <= minstret_d;
      minh_q     <= minh_d;
    end
  end

endmodule

// File: hdl/hpm_pkg.sv
// Width typedefs shared by the HPM design and its testbench
package hpm_pkg;

  // RV32 CSR data word
  typedef logic [31:0] xlen_t;

  // CSR address
  typedef logic [11:0] csr_addr_t;

  // Full counter accessed as two 32-bit halves
  typedef logic [63:0] counter_t;

  // mhpmevent selector value
  typedef logic [4:0] event_sel_t;

  // Functional unit of a committed instruction
  typedef logic [2:0] fu_t;

  // Operation class used for call and return detection
  typedef logic [1:0] op_t;

  // Destination register index
  typedef logic [4:0] reg_idx_t;

  // Up to two instructions retired per cycle
  typedef logic [1:0] retire_cnt_t;

endpackage

// File: hdl/hpm_top.sv
// HPM top level connecting classifier, counter bank and fixed CSRs
`include "hpm_settings.svh"

module hpm_top
  import hpm_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             debug_mode_i,   // Freezes all counting
  // CSR port
  input  csr_addr_t                        addr_i,
  input  logic                             we_i,
  input  xlen_t                            wdata_i,
  output xlen_t                            rdata_o,
  output logic                             access_fault_o,
  // Commit ports
  input  logic [`HPM_COMMIT_PORTS-1:0]     commit_ack_i,
  input  fu_t      [`HPM_COMMIT_PORTS-1:0] commit_fu_i,
  input  op_t      [`HPM_COMMIT_PORTS-1:0] commit_op_i,
  input  reg_idx_t [`HPM_COMMIT_PORTS-1:0] commit_rd_i,
  // Event levels from caches, MMU, frontend and issue
  input  logic                             icache_miss_i,
  input  logic                             dcache_miss_i,
  input  logic                             itlb_miss_i,
  input  logic                             dtlb_miss_i,
  input  logic                             exception_i,
  input  logic                             eret_i,
  input  logic                             mispredict_i,
  input  logic                             sb_full_i,
  input  logic                             if_empty_i,
  input  logic                             issue_stall_i
);

  logic                         load;
  logic                         store;
  logic                         branch;
  logic                         call;
  logic                         ret;
  logic                         int_instr;
  logic                         fp_instr;
  retire_cnt_t                  retire_cnt;
  logic [`HPM_NUM_COUNTERS-1:0] inhibit;
  xlen_t                        bank_rdata;

  hpm_commit_classifier i_classifier (
    .commit_ack_i (commit_ack_i),
    .commit_fu_i  (commit_fu_i),
    .commit_op_i  (commit_op_i),
    .commit_rd_i  (commit_rd_i),
    .load_o       (load),
    .store_o      (store),
    .branch_o     (branch),
    .call_o       (call),
    .return_o     (ret),
    .int_o        (int_instr),
    .fp_o         (fp_instr),
    .retire_cnt_o (retire_cnt)
  );

  hpm_counters i_counters (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .debug_mode_i  (debug_mode_i),
    .addr_i        (addr_i),
    .we_i          (we_i),
    .wdata_i       (wdata_i),
    .rdata_o       (bank_rdata),
    .icache_miss_i (icache_miss_i),
    .dcache_miss_i (dcache_miss_i),
    .itlb_miss_i   (itlb_miss_i),
    .dtlb_miss_i   (dtlb_miss_i),
    .exception_i   (exception_i),
    .eret_i        (eret_i),
    .mispredict_i  (mispredict_i),
    .sb_full_i     (sb_full_i),
    .if_empty_i    (if_empty_i),
    .issue_stall_i (issue_stall_i),
    .load_i        (load),
    .store_i       (store),
    .branch_i      (branch),
    .call_i        (call),
    .return_i      (ret),
    .int_i         (int_instr),
    .fp_i          (fp_instr),
    .inhibit_i     (inhibit)
  );

  hpm_fixed_csrs i_fixed_csrs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .debug_mode_i   (debug_mode_i),
    .addr_i         (addr_i),
    .we_i           (we_i),
    .wdata_i        (wdata_i),
    .retire_cnt_i   (retire_cnt),
    .bank_rdata_i   (bank_rdata),
    .inhibit_o      (inhibit),
    .rdata_o        (rdata_o),
    .access_fault_o (access_fault_o)
  );

endmodule

// File: include/hpm_settings.svh
// Sizes, CSR addresses, functional-unit, operation and event codes of the HPM
`ifndef HPM_SETTINGS_SVH
`define HPM_SETTINGS_SVH

// Sizes
`define HPM_NUM_COUNTERS 6  // mhpmcounter3 .. mhpmcounter8
`define HPM_COMMIT_PORTS 2
`define HPM_NUM_EVENTS   18 // Selector codes 0 .. 17

// Machine-range CSR map
`define CSR_MCOUNTINHIBIT 12'h320
`define CSR_MHPMEVENT3    12'h323
`define CSR_MCYCLE        12'hB00
`define CSR_MINSTRET      12'hB02
`define CSR_MHPMCOUNTER3  12'hB03
`define CSR_MCYCLEH       12'hB80
`define CSR_MINSTRETH     12'hB82
`define CSR_MHPMCOUNTER3H 12'hB83

// Read-only user aliases
`define CSR_CYCLE         12'hC00
`define CSR_INSTRET       12'hC02
`define CSR_HPMCOUNTER3   12'hC03
`define CSR_CYCLEH        12'hC80
`define CSR_INSTRETH      12'hC82
`define CSR_HPMCOUNTER3H  12'hC83

// Functional units of a committed instruction
`define FU_NONE      3'd0
`define FU_LOAD      3'd1
`define FU_STORE     3'd2
`define FU_ALU       3'd3
`define FU_CTRL_FLOW 3'd4
`define FU_MULT      3'd5
`define FU_FPU       3'd6

// Operations that matter for call and return detection
`define OP_OTHER 2'd0
`define OP_JAL   2'd1
`define OP_JALR  2'd2

// Event selector codes
`define EV_NONE        5'd0
`define EV_ICACHE_MISS 5'd1
`define EV_DCACHE_MISS 5'd2
`define EV_ITLB_MISS   5'd3
`define EV_DTLB_MISS   5'd4
`define EV_LOAD        5'd5
`define EV_STORE       5'd6
`define EV_EXCEPTION   5'd7
`define EV_ERET        5'd8
`define EV_BRANCH      5'd9
`define EV_MISPREDICT  5'd10
`define EV_CALL        5'd11
`define EV_RETURN      5'd12
`define EV_SB_FULL     5'd13
`define EV_IF_EMPTY    5'd14
`define EV_INT_INSTR   5'd15
`define EV_FP_INSTR    5'd16
`define EV_ISSUE_STALL 5'd17

`endif
